//--- verilog/trace_defs.svh
//****************************************************************************
// Trace unit constants
//   FIFO geometry and pointer width
//   Line format of ten 3-bit address beats
//   Periodic SE interval
//   Trace status (TS) bus codes
//****************************************************************************
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// FIFO geometry, depth is a power of two so pointers wrap by themselves
`define TRC_FIFO_DEPTH   16
`define TRC_PTR_W        4

// Line serialization format
`define TRC_BEATS        10
`define TRC_BEAT_W       3

// Clocks between periodic SE requests
`define TRC_SE_INTERVAL  64

// Trace status codes
`define TRC_TS_IDLE      4'b0000
`define TRC_TS_TRIGGER   4'b0001
`define TRC_TS_WAIT      4'b0011
// SE code is the base with the line kind in the low two bits
`define TRC_TS_SE_BASE   4'b0100
// Top TS bit set marks an address broadcast beat
`define TRC_TS_BROADCAST 1'b1

`endif

//--- verilog/tracePkg.sv
//****************************************************************************
// Trace unit types
//   Line kind carried in the low bits of every trace line
//   Trace line word with its field and beat decodings
//****************************************************************************
`default_nettype none

`include "trace_defs.svh"

package tracePkg;

    // Line kind, SE kinds get an SE code ahead of the address
    typedef enum logic [1:0]
    {
        normal = 2'b00,
        seIar  = 2'b01,
        seLr   = 2'b10,
        seCtr  = 2'b11
    } lineKind_e;

    // One 32-bit trace line
    // Field view as posted, beat view as serialized
    // Beat 0 sits in the most significant bits
    typedef union packed
    {
        struct packed
        {
            logic [`TRC_BEATS*`TRC_BEAT_W-1:0] addr;
            lineKind_e                         kind;
        } fields;
        struct packed
        {
            logic [0:`TRC_BEATS-1][`TRC_BEAT_W-1:0] beat;
            lineKind_e                              kind;
        } beats;
    } traceLine_u;

endpackage

`default_nettype wire

//--- verilog/serialIf.sv
//****************************************************************************
// Serializer to status encoder link
//   Odd-phase advance strobe
//   Line activity, SE slot flag, line kind and current beat
//   Source and sink modports
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

interface serialIf
    import tracePkg::*;
();

    // High on odd trace cycles, TS may only change then
    logic                   advance;
    // Head line of the FIFO is being sent
    logic                   lineActive;
    // Current slot carries the SE code instead of a beat
    logic                   seSlot;
    lineKind_e              lineKind;
    logic [`TRC_BEAT_W-1:0] beat;

    // Serializer side
    modport source (output advance, lineActive, seSlot, lineKind, beat);

    // Status encoder side
    modport sink (input advance, lineActive, seSlot, lineKind, beat);

endinterface

`default_nettype wire

//--- verilog/traceLineFifo.sv
//****************************************************************************
// Trace line FIFO
//   Line storage with wrapping write and read pointers
//   Up/down occupancy count
//   Credit return pulse per completed line
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module traceLineFifo
    import tracePkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    input  wire             traceEnable_i,
    input  wire             postValid_i,
    input  wire traceLine_u postLine_i,
    input  wire             lineDone_i,
    output logic            headValid_o,
    output traceLine_u      headLine_o,
    output logic            fifoEmpty_o,
    output logic            creditReturn_o
);

    // One extra bit so a full FIFO is distinct from empty
    localparam int CNT_W = `TRC_PTR_W + 1;

    traceLine_u            lineMem [`TRC_FIFO_DEPTH];
    logic [`TRC_PTR_W-1:0] wrPtr;
    logic [`TRC_PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0]      lineCount;
    logic                  postEntry;

    // Poster only posts while it holds a credit, so no full check here
    assign postEntry = postValid_i & traceEnable_i;

    //************************************************************************
    // Line storage
    //************************************************************************
    always_ff @(posedge clk_i)
    begin
        if (postEntry)
        begin
            lineMem[wrPtr] <= postLine_i;
        end
    end

    //************************************************************************
    // Pointers, occupancy and credits
    //************************************************************************
    always_ff @(posedge clk_i)
    begin
        if (reset_i | ~traceEnable_i)
        begin
            wrPtr          <= '0;
            rdPtr          <= '0;
            lineCount      <= '0;
            creditReturn_o <= 1'b0;
        end
        else
        begin
            // Pointers wrap at the FIFO depth
            if (postEntry)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (lineDone_i)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Post and completion together leave the count alone
            case ({postEntry, lineDone_i})
                2'b10:   lineCount <= lineCount + 1'b1;
                2'b01:   lineCount <= lineCount - 1'b1;
                default: lineCount <= lineCount;
            endcase
            // One credit back per finished line, a clock after its last beat
            creditReturn_o <= lineDone_i;
        end
    end

    // Head of queue as seen by the serializer
    assign headValid_o = |lineCount;
    assign headLine_o  = lineMem[rdPtr];
    assign fifoEmpty_o = ~|lineCount;

endmodule

`default_nettype wire

//--- verilog/lineSerializer.sv
//****************************************************************************
// Trace line serializer
//   Trace-cycle phase register, odd phase gives the advance strobe
//   Beat sequencing FSM, SE code slot then beats 0 through 9
//   Line completion pulse back to the FIFO
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module lineSerializer
    import tracePkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    input  wire             traceEnable_i,
    input  wire             triggerEvent_i,
    input  wire             headValid_i,
    input  wire traceLine_u headLine_i,
    output logic            lineDone_o,
    serialIf.source         ser
);

    // State encoding
    // Head slot sends the SE code for SE lines, beat 0 for normal lines
    // State n above head sends beat n-1
    localparam logic [3:0] ST_HEAD        = 4'd0;
    localparam logic [3:0] ST_FIRST_BEAT  = 4'd1;
    localparam logic [3:0] ST_SECOND_BEAT = 4'd2;
    localparam logic [3:0] ST_LAST_BEAT   = 4'(`TRC_BEATS);

    logic       oddPhase;
    logic [3:0] serState;
    logic [3:0] nxtSerState;
    logic [3:0] beatSel;
    logic       seLine;
    logic       serStep;

    //************************************************************************
    // Next state
    //************************************************************************
    // Any kind other than normal carries an SE code
    assign seLine = (headLine_i.fields.kind != normal);

    always_comb
    begin
        case (serState)
            ST_HEAD:
            begin
                // Normal line already sent beat 0 in the head slot
                nxtSerState = seLine ? ST_FIRST_BEAT : ST_SECOND_BEAT;
            end
            ST_LAST_BEAT:
            begin
                nxtSerState = ST_HEAD;
            end
            default:
            begin
                nxtSerState = serState + 1'b1;
            end
        endcase
    end

    // Move on odd phase with a line present
    // A trigger takes the TS slot, so the FSM holds and no beat is lost
    assign serStep = oddPhase & ~triggerEvent_i & headValid_i;

    //************************************************************************
    // Phase and state registers
    //************************************************************************
    always_ff @(posedge clk_i)
    begin
        if (reset_i | ~traceEnable_i)
        begin
            // First enabled cycle is even
            oddPhase <= 1'b0;
            serState <= ST_HEAD;
        end
        else
        begin
            oddPhase <= ~oddPhase;
            if (serStep)
            begin
                serState <= nxtSerState;
            end
        end
    end

    // Last beat leaves with this step, FIFO pops at the same edge
    assign lineDone_o = serStep & (serState == ST_LAST_BEAT);

    //************************************************************************
    // Progress towards the status encoder
    //************************************************************************
    assign beatSel = (serState == ST_HEAD) ? 4'd0 : serState - 1'b1;

    assign ser.advance    = oddPhase;
    assign ser.lineActive = headValid_i;
    assign ser.seSlot     = (serState == ST_HEAD) & seLine;
    assign ser.lineKind   = headLine_i.beats.kind;
    assign ser.beat       = headLine_i.beats.beat[beatSel];

endmodule

`default_nettype wire

//--- verilog/seGenerator.sv
//****************************************************************************
// Synchronizing event generator
//   Down counter over the SE interval
//   Restart on wait or stop with an empty FIFO
//   Qualified SE request towards the poster
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module seGenerator (
    input  wire  clk_i,
    input  wire  reset_i,
    input  wire  traceEnable_i,
    input  wire  msrWe_i,
    input  wire  stopReq_i,
    input  wire  fifoEmpty_i,
    output logic seRequest_o
);

    localparam int CNT_W = $clog2(`TRC_SE_INTERVAL);

    logic [CNT_W-1:0] seCount;
    logic             seExpired;
    logic             waitOrStop;
    logic             seCtrRestart;

    // Core in wait state or asked to stop
    assign waitOrStop = msrWe_i | stopReq_i;

    // Long enough in wait or stop that the FIFO drained
    // Force zero so an SE goes out on leaving that state
    assign seCtrRestart = waitOrStop & fifoEmpty_i;

    //************************************************************************
    // Interval counter
    //************************************************************************
    always_ff @(posedge clk_i)
    begin
        if (reset_i | ~traceEnable_i)
        begin
            seCount   <= '0;
            seExpired <= 1'b0;
        end
        else if (seCtrRestart)
        begin
            seCount   <= '0;
            seExpired <= 1'b1;
        end
        else if (seRequest_o)
        begin
            // Reload, next request one full interval later
            seCount   <= CNT_W'(`TRC_SE_INTERVAL - 1);
            seExpired <= 1'b0;
        end
        else
        begin
            if (seCount != '0)
            begin
                seCount <= seCount - 1'b1;
            end
            // Armed once the count reaches zero, held while blocked
            seExpired <= (seCount <= CNT_W'(1));
        end
    end

    // No SE while disabled, in wait or in stop
    assign seRequest_o = seExpired & traceEnable_i & ~waitOrStop;

endmodule

`default_nettype wire

//--- verilog/traceStatusEncoder.sv
//****************************************************************************
// Trace status encoder
//   Priority selection of the TS code
//   TS register, loaded on the odd phase only
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module traceStatusEncoder (
    input  wire        clk_i,
    input  wire        reset_i,
    input  wire        traceEnable_i,
    input  wire        triggerEvent_i,
    input  wire        stopAck_i,
    input  wire        msrWe_i,
    serialIf.sink      ser,
    output logic [3:0] traceStatus_o
);

    logic [3:0] nxtTsCode;
    logic       stopWait;

    // Core stopped or in wait state
    assign stopWait = stopAck_i | msrWe_i;

    //************************************************************************
    // TS code priority
    //************************************************************************
    always_comb
    begin
        if (triggerEvent_i)
        begin
            // Trigger wins over any FIFO traffic
            nxtTsCode = `TRC_TS_TRIGGER;
        end
        else if (ser.lineActive & ser.seSlot)
        begin
            nxtTsCode = `TRC_TS_SE_BASE | {2'b00, ser.lineKind};
        end
        else if (ser.lineActive)
        begin
            // Address broadcast
            nxtTsCode = {`TRC_TS_BROADCAST, ser.beat};
        end
        else if (stopWait)
        begin
            nxtTsCode = `TRC_TS_WAIT;
        end
        else
        begin
            nxtTsCode = `TRC_TS_IDLE;
        end
    end

    //************************************************************************
    // TS register
    //************************************************************************
    // Stable for two clocks, observers sample it on the even phase
    always_ff @(posedge clk_i)
    begin
        if (reset_i | ~traceEnable_i)
        begin
            traceStatus_o <= `TRC_TS_IDLE;
        end
        else if (ser.advance)
        begin
            traceStatus_o <= nxtTsCode;
        end
    end

endmodule

`default_nettype wire

//--- verilog/traceUnit.sv
//****************************************************************************
// Trace unit top level
//   Line FIFO, serializer, SE generator and TS encoder
//   Serializer to encoder link over one interface
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

module traceUnit
    import tracePkg::*;
(
    input  wire         clk_i,
    input  wire         reset_i,
    input  wire         traceEnable_i,
    input  wire         postValid_i,
    input  wire  [31:0] postLine_i,
    input  wire         triggerEvent_i,
    input  wire         stopAck_i,
    input  wire         msrWe_i,
    input  wire         stopReq_i,
    output logic        creditReturn_o,
    output logic        fifoEmpty_o,
    output logic        seRequest_o,
    output logic        traceCycle_o,
    output logic [3:0]  traceStatus_o
);

    // FIFO head towards the serializer
    logic       headValid;
    traceLine_u headLine;
    // Line completion back to the FIFO
    logic       lineDone;

    serialIf ser ();

    // Line storage and credit return
    traceLineFifo u_fifo (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .traceEnable_i  (traceEnable_i),
        .postValid_i    (postValid_i),
        .postLine_i     (postLine_i),
        .lineDone_i     (lineDone),
        .headValid_o    (headValid),
        .headLine_o     (headLine),
        .fifoEmpty_o    (fifoEmpty_o),
        .creditReturn_o (creditReturn_o)
    );

    // Phase and beat sequencing
    lineSerializer u_serializer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .traceEnable_i  (traceEnable_i),
        .triggerEvent_i (triggerEvent_i),
        .headValid_i    (headValid),
        .headLine_i     (headLine),
        .lineDone_o     (lineDone),
        .ser            (ser.source)
    );

    // Periodic SE requests
    seGenerator u_seGen (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .traceEnable_i (traceEnable_i),
        .msrWe_i       (msrWe_i),
        .stopReq_i     (stopReq_i),
        .fifoEmpty_i   (fifoEmpty_o),
        .seRequest_o   (seRequest_o)
    );

    // TS bus
    traceStatusEncoder u_encoder (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .traceEnable_i  (traceEnable_i),
        .triggerEvent_i (triggerEvent_i),
        .stopAck_i      (stopAck_i),
        .msrWe_i        (msrWe_i),
        .ser            (ser.sink),
        .traceStatus_o  (traceStatus_o)
    );

    // Trace cycle is the serializer phase
    assign traceCycle_o = ser.advance;

endmodule

`default_nettype wire

//--- testbench/traceUnit_properties.sv
//****************************************************************************
// Trace unit protocol checks
//   Quiet outputs after reset
//   TS changes only across an advance cycle
//   No SE request in wait or stop
//   Returned credits bounded by posted lines
//   Bind into the trace unit top level
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module traceUnit_properties (
    input wire       clk_i,
    input wire       reset_i,
    input wire       traceEnable_i,
    input wire       postValid_i,
    input wire       msrWe_i,
    input wire       stopReq_i,
    input wire       creditReturn_i,
    input wire       seRequest_i,
    input wire       traceCycle_i,
    input wire [3:0] traceStatus_i
);

    // Running totals of posts and returned credits
    int unsigned postCount;
    int unsigned creditCount;
    // Seen by the testbench top
    int unsigned assertFails = 0;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            postCount   <= 0;
            creditCount <= 0;
        end
        else
        begin
            if (postValid_i & traceEnable_i)
            begin
                postCount <= postCount + 1;
            end
            if (creditReturn_i)
            begin
                creditCount <= creditCount + 1;
            end
        end
    end

    //************************************************************************
    // Protocol properties
    //************************************************************************
    quietAfterReset: assert property (@(posedge clk_i)
        reset_i |=> (traceStatus_i == `TRC_TS_IDLE) && !creditReturn_i &&
                    !seRequest_i && !traceCycle_i)
    else
    begin
        assertFails++;
        $error("Outputs not quiet after reset");
    end

    // TS register loads only at the end of an advance cycle
    tsOnlyOnAdvance: assert property (@(posedge clk_i) disable iff (reset_i)
        (traceStatus_i != $past(traceStatus_i)) |->
            ($past(traceCycle_i) || !$past(traceEnable_i)))
    else
    begin
        assertFails++;
        $error("TS changed outside an advance cycle");
    end

    noSeInWaitOrStop: assert property (@(posedge clk_i)
        (msrWe_i || stopReq_i) |-> !seRequest_i)
    else
    begin
        assertFails++;
        $error("SE request raised in wait or stop");
    end

    creditsBounded: assert property (@(posedge clk_i) disable iff (reset_i)
        creditCount <= postCount)
    else
    begin
        assertFails++;
        $error("More credits returned than lines posted");
    end

endmodule

bind traceUnit traceUnit_properties u_props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .traceEnable_i  (traceEnable_i),
    .postValid_i    (postValid_i),
    .msrWe_i        (msrWe_i),
    .stopReq_i      (stopReq_i),
    .creditReturn_i (creditReturn_o),
    .seRequest_i    (seRequest_o),
    .traceCycle_i   (traceCycle_o),
    .traceStatus_i  (traceStatus_o)
);

`default_nettype wire

//--- testbench/traceUnitTb.sv
//****************************************************************************
// Trace unit testbench
//   Clock, reset and LFSR stimulus
//   Credit-keeping poster and trigger driver
//   Reference queue of expected TS codes checked on the even phase
//   SE request and wait code checks
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "trace_defs.svh"

module traceUnitTb;

    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 1000;

    logic        clk;
    logic        reset;
    logic        traceEnable;
    logic        postValid;
    logic [31:0] postLine;
    logic        triggerEvent;
    logic        stopAck;
    logic        msrWe;
    logic        stopReq;
    logic        creditReturn;
    logic        fifoEmpty;
    logic        seRequest;
    logic        traceCycle;
    logic [3:0]  traceStatus;

    logic [15:0] lfsrState;
    logic [3:0]  expCodes [$];
    logic [31:0] rnd;
    int          credits;
    int          seSeen;
    bit          expectTrigger;
    bit          expectWait;

    traceUnit u_dut (
        .clk_i          (clk),
        .reset_i        (reset),
        .traceEnable_i  (traceEnable),
        .postValid_i    (postValid),
        .postLine_i     (postLine),
        .triggerEvent_i (triggerEvent),
        .stopAck_i      (stopAck),
        .msrWe_i        (msrWe),
        .stopReq_i      (stopReq),
        .creditReturn_o (creditReturn),
        .fifoEmpty_o    (fifoEmpty),
        .seRequest_o    (seRequest),
        .traceCycle_o   (traceCycle),
        .traceStatus_o  (traceStatus)
    );

    always #CLK_HALF clk = ~clk;

    //************************************************************************
    // Failure reporting
    //************************************************************************
    task automatic abortRun(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        abortRun($sformatf("Mismatch at %0d ns: %s", $time, msg));
    endtask

    // Bound protocol assertions count their failures
    always @(negedge clk)
    begin
        if (u_dut.u_props.assertFails != 0)
        begin
            abortRun("A bound protocol assertion failed");
        end
    end

    // SE request follows msrWe_i and stopReq_i directly so it is counted mid-cycle
    always @(negedge clk)
    begin
        if (seRequest)
        begin
            seSeen++;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val       = {val[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return val;
    endfunction

    //************************************************************************
    // Reference model and monitor
    //************************************************************************
    // SE code first for SE kinds and then beats from the top of the word down
    task automatic expectLine(input logic [31:0] word);
        if (word[1:0] != 2'b00)
        begin
            expCodes.push_back(`TRC_TS_SE_BASE | {2'b00, word[1:0]});
        end
        for (int i = 0; i < `TRC_BEATS; i++)
        begin
            expCodes.push_back({`TRC_TS_BROADCAST, word[31-3*i -: 3]});
        end
    endtask

    // One TS sample per even cycle
    // Idle and wait codes carry no line data
    task automatic checkStatus();
        logic [3:0] expCode;
        if (expectTrigger)
        begin
            assert (traceStatus == `TRC_TS_TRIGGER)
            else reportMismatch($sformatf("TS %b, expected trigger code", traceStatus));
            expectTrigger = 1'b0;
        end
        else if (expectWait)
        begin
            assert (traceStatus == `TRC_TS_WAIT)
            else reportMismatch($sformatf("TS %b, expected wait code", traceStatus));
        end
        else if ((traceStatus != `TRC_TS_IDLE) && (traceStatus != `TRC_TS_WAIT))
        begin
            assert (expCodes.size() != 0)
            else reportMismatch($sformatf("TS %b with no line pending", traceStatus));
            expCode = expCodes.pop_front();
            assert (traceStatus == expCode)
            else reportMismatch($sformatf("TS %b, expected %b", traceStatus, expCode));
        end
    endtask

    // Move to the drive point of the next cycle and sample outputs there
    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
        if (creditReturn)
        begin
            credits++;
        end
        assert (credits <= `TRC_FIFO_DEPTH)
        else reportMismatch("more credits returned than lines posted");
        if (!traceCycle)
        begin
            checkStatus();
        end
        postValid    = 1'b0;
        triggerEvent = 1'b0;
    endtask

    //************************************************************************
    // Stimulus
    //************************************************************************
    // Post one line once a credit is held
    task automatic postOne(input logic [31:0] word);
        int waited;
        waited = 0;
        while (credits == 0)
        begin
            tick();
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                abortRun("Timeout waiting for a returned credit");
            end
        end
        postValid = 1'b1;
        postLine  = word;
        credits--;
        expectLine(word);
        tick();
    endtask

    // Trigger only counts in an advance cycle
    task automatic pulseTrigger();
        if (!traceCycle)
        begin
            tick();
        end
        triggerEvent  = 1'b1;
        expectTrigger = 1'b1;
        tick();
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while ((credits != `TRC_FIFO_DEPTH) || (expCodes.size() != 0))
        begin
            tick();
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                abortRun("Timeout waiting for the FIFO to drain");
            end
        end
        tick();
        assert (fifoEmpty)
        else reportMismatch("FIFO not empty after all credits returned");
    endtask

    task automatic waitSeRequest();
        int waited;
        int startCount;
        waited     = 0;
        startCount = seSeen;
        while (seSeen == startCount)
        begin
            tick();
            waited++;
            if (waited > 2 * `TRC_SE_INTERVAL + 8)
            begin
                abortRun("Timeout waiting for an SE request");
            end
        end
    endtask

    // Core held in wait or stop by the caller
    // TS shows the wait code and no SE request may appear
    task automatic checkSeHeldOff(input string cause);
        int startCount;
        startCount = seSeen;
        repeat (4) tick();
        expectWait = 1'b1;
        repeat (3 * `TRC_SE_INTERVAL) tick();
        assert (seSeen == startCount)
        else reportMismatch($sformatf("SE request while %s", cause));
        expectWait = 1'b0;
    endtask

    initial
    begin
        clk           = 1'b0;
        reset         = 1'b1;
        traceEnable   = 1'b1;
        postValid     = 1'b0;
        postLine      = '0;
        triggerEvent  = 1'b0;
        stopAck       = 1'b0;
        msrWe         = 1'b0;
        stopReq       = 1'b0;
        lfsrState     = 16'd64229;
        credits       = `TRC_FIFO_DEPTH;
        seSeen        = 0;
        expectTrigger = 1'b0;
        expectWait    = 1'b0;

        // Outputs quiet at the end of a two-cycle reset
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        assert ((traceStatus == `TRC_TS_IDLE) && fifoEmpty && !creditReturn &&
                !seRequest && !traceCycle)
        else reportMismatch("outputs not quiet after reset");
        reset = 1'b0;
        tick();

        // Single normal line
        rnd = randBits(30);
        postOne({rnd[29:0], 2'b00});
        waitDrained();

        // One line of each SE kind
        for (int kind = 1; kind < 4; kind++)
        begin
            rnd = randBits(30);
            postOne({rnd[29:0], kind[1:0]});
            waitDrained();
        end

        // Random lines with random gaps and triggers
        for (int n = 0; n < 24; n++)
        begin
            repeat (randBits(2))
            begin
                if (randBits(2) == 0)
                begin
                    pulseTrigger();
                end
                else
                begin
                    tick();
                end
            end
            postOne(randBits(32));
        end
        waitDrained();

        // Fill the FIFO back to back
        repeat (`TRC_FIFO_DEPTH)
        begin
            postOne(randBits(32));
        end
        waitDrained();

        // SE requests run freely and stay off in wait or stop
        waitSeRequest();
        msrWe = 1'b1;
        checkSeHeldOff("msrWe held");
        msrWe = 1'b0;
        waitSeRequest();
        stopReq = 1'b1;
        stopAck = 1'b1;
        checkSeHeldOff("stop requested");
        stopReq = 1'b0;
        stopAck = 1'b0;
        waitSeRequest();
        tick();

        if ((expCodes.size() == 0) && (credits == `TRC_FIFO_DEPTH) &&
            (u_dut.u_props.assertFails == 0))
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            abortRun("Lines pending or a protocol assertion failed at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/tracePkg.sv
verilog/serialIf.sv
verilog/traceLineFifo.sv
verilog/lineSerializer.sv
verilog/seGenerator.sv
verilog/traceStatusEncoder.sv
verilog/traceUnit.sv
testbench/traceUnit_properties.sv
testbench/traceUnitTb.sv

//--- Makefile
# Verilator build and run of the trace unit testbench

SIM_BIN = obj_dir/VtraceUnitTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module traceUnitTb -Mdir obj_dir

run: build
	./$(SIM_BIN) +verilator+error+limit+10 | tee sim.log
	grep -q "^test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module traceUnitTb

clean:
	rm -rf obj_dir sim.log
